// ==== source/zynet_ctrl_pkg.sv ====
`default_nettype none

package zynet_ctrl_pkg;

    // sequencing states shared by the conv, serializer and fc layers
    //   IDLE  waiting for work
    //   BUSY  filling, writing or finishing
    //   SEND  holding a result for the next layer
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        SEND
    } layer_state_e;

endpackage

`default_nettype wire

// ==== source/zynet_coef_pkg.sv ====
`default_nettype none

package zynet_coef_pkg;

    // frame geometry
    localparam int INPUT_LENGTH  = 19;
    localparam int KERNEL_LENGTH = 4;
    localparam int CONV_LENGTH   = INPUT_LENGTH - KERNEL_LENGTH + 1;
    // divide by CONV_LENGTH when averaging
    localparam int POOL_SHIFT    = 4;

    localparam int NUM_KERNELS = 4;
    localparam int OUTPUT_SIZE = 3;

    // coefficients carry six fraction bits
    localparam int COEF_WIDTH     = 8;
    localparam int COEF_FRAC_BITS = 6;
    localparam int BIAS_WIDTH     = 16;

    // one row per kernel, tap 0 meets the oldest sample
    localparam logic signed [COEF_WIDTH-1:0] KERNEL_COEF [NUM_KERNELS][KERNEL_LENGTH] = '{
        '{ 8'sd32,   8'sd64, -8'sd48,  8'sd16},
        '{-8'sd20,   8'sd40,  8'sd40, -8'sd20},
        '{ 8'sd96,  -8'sd64,  8'sd8,   8'sd24},
        '{-8'sd12,  -8'sd28,  8'sd72,  8'sd56}
    };

    // one row per score, column k weights feature k
    localparam logic signed [COEF_WIDTH-1:0] FC_WEIGHT [OUTPUT_SIZE][NUM_KERNELS] = '{
        '{ 8'sd80,  -8'sd36,   8'sd52,  8'sd18},
        '{-8'sd44,   8'sd90,  -8'sd16,  8'sd60},
        '{ 8'sd24,   8'sd30, -8'sd100, -8'sd70}
    };

    // biases in data format, 12 fraction bits
    localparam logic signed [BIAS_WIDTH-1:0] FC_BIAS [OUTPUT_SIZE] = '{
        16'sd1024,
        -16'sd2048,
        16'sd512
    };

endpackage

`default_nettype wire

// ==== source/conv_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

module conv_layer #(
    parameter int WORD_SIZE    = 16,
    parameter int INT_BITS     = 4,
    parameter int KERNEL_INDEX = 0
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        start_i,
    input  logic                        valid_i,
    input  logic signed [WORD_SIZE-1:0] data_i,
    output logic                        ready_o,
    output logic                        valid_o,
    input  logic                        yumi_i,
    output logic signed [WORD_SIZE-1:0] data_o
);
    import zynet_ctrl_pkg::*;
    import zynet_coef_pkg::*;

    localparam int FRAC_BITS  = WORD_SIZE - INT_BITS;
    localparam int SUM_WIDTH  = WORD_SIZE + COEF_WIDTH + $clog2(KERNEL_LENGTH);
    localparam int FILL_WIDTH = $clog2(KERNEL_LENGTH);
    // largest word is 2^(INT_BITS-1) less one lsb
    localparam logic signed [SUM_WIDTH-1:0] SAT_MAX =
        (SUM_WIDTH'(1) << (FRAC_BITS + INT_BITS - 1)) - 1;
    localparam logic signed [SUM_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

    layer_state_e state;
    logic [FILL_WIDTH-1:0] fill;
    logic accept;
    logic produce;

    // previous KERNEL_LENGTH-1 samples, index 0 oldest
    logic signed [WORD_SIZE-1:0] window [KERNEL_LENGTH-1];
    logic signed [WORD_SIZE-1:0] taps [KERNEL_LENGTH];
    logic signed [SUM_WIDTH-1:0] sum;
    logic signed [SUM_WIDTH-1:0] scaled;
    logic signed [WORD_SIZE-1:0] result;

    // a held result may leave in the same cycle a new sample enters
    assign ready_o = (state != SEND) || yumi_i;
    assign valid_o = state == SEND;
    assign accept  = valid_i && ready_o && (state != IDLE) && !start_i;
    assign produce = accept && (fill == FILL_WIDTH'(KERNEL_LENGTH - 1));

    always_comb begin
        for (int k = 0; k < KERNEL_LENGTH - 1; k++) begin
            taps[k] = window[k];
        end
        taps[KERNEL_LENGTH-1] = data_i;
    end

    // full width MAC, then back to data format and clip
    always_comb begin
        sum = '0;
        for (int k = 0; k < KERNEL_LENGTH; k++) begin
            sum = sum + taps[k] * KERNEL_COEF[KERNEL_INDEX][k];
        end
        scaled = sum >>> COEF_FRAC_BITS;
        if (scaled > SAT_MAX) begin
            result = SAT_MAX[WORD_SIZE-1:0];
        end else if (scaled < SAT_MIN) begin
            result = SAT_MIN[WORD_SIZE-1:0];
        end else begin
            result = scaled[WORD_SIZE-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
            fill  <= '0;
        end else begin
            if (start_i) begin
                fill <= '0;
            end else if (accept && !produce) begin
                fill <= fill + 1'b1;
            end
            case (state)
                IDLE: if (start_i) state <= BUSY;
                BUSY: if (produce) state <= SEND;
                SEND: if (yumi_i && !produce) state <= BUSY;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            for (int k = 0; k < KERNEL_LENGTH - 1; k++) begin
                window[k] <= taps[k + 1];
            end
        end
        if (produce) begin
            data_o <= result;
        end
    end

endmodule

`default_nettype wire

// ==== source/pooling_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pooling_layer #(
    parameter int WORD_SIZE = 16,
    parameter int INT_BITS  = 4
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  logic signed [WORD_SIZE-1:0] data_i,
    output logic                        yumi_o,
    output logic                        valid_o,
    output logic signed [WORD_SIZE-1:0] data_o,
    input  logic                        clear_i
);
    import zynet_coef_pkg::*;

    localparam int FRAC_BITS = WORD_SIZE - INT_BITS;
    localparam int ACC_WIDTH = WORD_SIZE + POOL_SHIFT;
    localparam int CNT_WIDTH = $clog2(CONV_LENGTH);
    localparam logic [WORD_SIZE-1:0] MAG_MAX =
        (WORD_SIZE'(1) << (FRAC_BITS + INT_BITS - 1)) - 1;
    localparam logic [WORD_SIZE-1:0] MOST_NEG = {1'b1, {(WORD_SIZE-1){1'b0}}};

    logic [WORD_SIZE-1:0] mag;
    logic [ACC_WIDTH-1:0] acc;
    logic [CNT_WIDTH-1:0] count;
    logic take;

    assign yumi_o = !valid_o;
    assign take   = valid_i && yumi_o;
    // average is the sum with the low POOL_SHIFT bits dropped
    assign data_o = acc[ACC_WIDTH-1:POOL_SHIFT];

    // the most negative word has no positive twin, so it clips
    always_comb begin
        if (!data_i[WORD_SIZE-1]) begin
            mag = data_i;
        end else if (data_i == MOST_NEG) begin
            mag = MAG_MAX;
        end else begin
            mag = -data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            acc     <= '0;
            count   <= '0;
            valid_o <= 1'b0;
        end else if (take) begin
            acc <= acc + ACC_WIDTH'(mag);
            if (count == CNT_WIDTH'(CONV_LENGTH - 1)) begin
                count   <= '0;
                valid_o <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fc_output_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fc_output_layer #(
    parameter int WORD_SIZE = 16
) (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    input  logic [zynet_coef_pkg::NUM_KERNELS-1:0]                valid_i,
    input  logic [zynet_coef_pkg::NUM_KERNELS-1:0][WORD_SIZE-1:0] data_i,
    output logic                                                 done_o,
    output logic                                                 wen_o,
    input  logic                                                 full_i,
    output logic [WORD_SIZE-1:0]                                 data_o
);
    import zynet_ctrl_pkg::*;
    import zynet_coef_pkg::*;

    localparam int IDX_WIDTH = $clog2(NUM_KERNELS);

    layer_state_e state;
    logic [IDX_WIDTH-1:0] idx;
    logic capture;
    logic [NUM_KERNELS-1:0][WORD_SIZE-1:0] features;

    // every pooling layer has finished its average
    assign capture = (state == IDLE) && (&valid_i);
    assign wen_o   = (state == BUSY) && !full_i;
    assign done_o  = state == SEND;
    assign data_o  = features[idx];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (capture) begin
                        state <= BUSY;
                        idx   <= '0;
                    end
                end
                BUSY: begin
                    if (wen_o) begin
                        if (idx == IDX_WIDTH'(NUM_KERNELS - 1)) begin
                            state <= SEND;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                // done_o clears the pooling layers here
                SEND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            features <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/double_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module double_fifo #(
    parameter int WORD_SIZE  = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 wen_i,
    input  logic [WORD_SIZE-1:0] data_i,
    output logic                 full_o,
    input  logic                 ren_i,
    output logic                 empty_o,
    output logic [WORD_SIZE-1:0] data_o
);
    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [WORD_SIZE-1:0] mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wptr;
    logic [PTR_WIDTH-1:0] rptr;
    logic [CNT_WIDTH-1:0] count;
    logic push;
    logic pop;

    assign full_o  = count == CNT_WIDTH'(FIFO_DEPTH);
    assign empty_o = count == '0;
    assign push    = wen_i && !full_o;
    assign pop     = ren_i && !empty_o;
    // head word shows before it is read
    assign data_o  = mem[rptr];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wptr <= (wptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (pop) begin
                rptr <= (rptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            count <= count + CNT_WIDTH'(push) - CNT_WIDTH'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wptr] <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/fc_layer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fc_layer #(
    parameter int WORD_SIZE = 16,
    parameter int INT_BITS  = 4
) (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    input  logic signed [WORD_SIZE-1:0]                          data_i,
    input  logic                                                 empty_i,
    output logic                                                 ren_o,
    output logic                                                 valid_o,
    input  logic                                                 yumi_i,
    output logic [zynet_coef_pkg::OUTPUT_SIZE-1:0][WORD_SIZE-1:0] data_o
);
    import zynet_ctrl_pkg::*;
    import zynet_coef_pkg::*;

    localparam int FRAC_BITS = WORD_SIZE - INT_BITS;
    // one spare bit for the bias add
    localparam int ACC_WIDTH = WORD_SIZE + COEF_WIDTH + $clog2(NUM_KERNELS) + 1;
    localparam int CNT_WIDTH = $clog2(NUM_KERNELS);
    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX =
        (ACC_WIDTH'(1) << (FRAC_BITS + INT_BITS - 1)) - 1;
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -SAT_MAX - 1;

    layer_state_e state;
    logic [CNT_WIDTH-1:0] count;
    logic signed [ACC_WIDTH-1:0] acc [OUTPUT_SIZE];
    logic signed [ACC_WIDTH-1:0] biased [OUTPUT_SIZE];
    logic [OUTPUT_SIZE-1:0][WORD_SIZE-1:0] score;

    // reads only while collecting features
    assign ren_o   = (state == IDLE) && !empty_i;
    assign valid_o = state == SEND;

    always_comb begin
        for (int o = 0; o < OUTPUT_SIZE; o++) begin
            biased[o] = (acc[o] >>> COEF_FRAC_BITS) + FC_BIAS[o];
            if (biased[o] > SAT_MAX) begin
                score[o] = SAT_MAX[WORD_SIZE-1:0];
            end else if (biased[o] < SAT_MIN) begin
                score[o] = SAT_MIN[WORD_SIZE-1:0];
            end else begin
                score[o] = biased[o][WORD_SIZE-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
            count <= '0;
            for (int o = 0; o < OUTPUT_SIZE; o++) begin
                acc[o] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (ren_o) begin
                        for (int o = 0; o < OUTPUT_SIZE; o++) begin
                            acc[o] <= acc[o] + data_i * FC_WEIGHT[o][count];
                        end
                        if (count == CNT_WIDTH'(NUM_KERNELS - 1)) begin
                            count <= '0;
                            state <= BUSY;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                // scores are registered here, sums start over
                BUSY: begin
                    state <= SEND;
                    for (int o = 0; o < OUTPUT_SIZE; o++) begin
                        acc[o] <= '0;
                    end
                end
                SEND: if (yumi_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == BUSY) begin
            data_o <= score;
        end
    end

endmodule

`default_nettype wire

// ==== source/zynet.sv ====
`timescale 1ns/1ns
`default_nettype none

module zynet #(
    parameter int WORD_SIZE  = 16,
    parameter int INT_BITS   = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    input  logic                                                 start_i,
    input  logic signed [WORD_SIZE-1:0]                          data_i,
    input  logic                                                 valid_i,
    output logic                                                 ready_o,
    output logic [zynet_coef_pkg::OUTPUT_SIZE-1:0][WORD_SIZE-1:0] data_o,
    output logic                                                 valid_o,
    input  logic                                                 yumi_i
);
    import zynet_coef_pkg::*;

    logic [NUM_KERNELS-1:0] conv_ready;
    logic [NUM_KERNELS-1:0] conv_valid;
    logic [NUM_KERNELS-1:0] pool_yumi;
    logic [NUM_KERNELS-1:0] pool_valid;
    logic [NUM_KERNELS-1:0][WORD_SIZE-1:0] conv_data;
    logic [NUM_KERNELS-1:0][WORD_SIZE-1:0] pool_data;

    logic feat_done;
    logic feat_wen;
    logic [WORD_SIZE-1:0] feat_data;
    logic fifo_full;
    logic fifo_empty;
    logic [WORD_SIZE-1:0] fifo_data;
    logic fc_ren;

    // kernels run in lockstep, kernel 0 speaks for all
    assign ready_o = conv_ready[0];

    for (genvar i = 0; i < NUM_KERNELS; i++) begin : g_kernel
        conv_layer #(
            .WORD_SIZE   (WORD_SIZE),
            .INT_BITS    (INT_BITS),
            .KERNEL_INDEX(i)
        ) u_conv (
            .clk_i  (clk_i),
            .reset_i(reset_i),
            .start_i(start_i),
            .valid_i(valid_i),
            .data_i (data_i),
            .ready_o(conv_ready[i]),
            .valid_o(conv_valid[i]),
            .yumi_i (pool_yumi[i]),
            .data_o (conv_data[i])
        );

        pooling_layer #(
            .WORD_SIZE(WORD_SIZE),
            .INT_BITS (INT_BITS)
        ) u_pool (
            .clk_i  (clk_i),
            .reset_i(reset_i),
            .valid_i(conv_valid[i]),
            .data_i (conv_data[i]),
            .yumi_o (pool_yumi[i]),
            .valid_o(pool_valid[i]),
            .data_o (pool_data[i]),
            .clear_i(feat_done)
        );
    end

    fc_output_layer #(
        .WORD_SIZE(WORD_SIZE)
    ) u_serializer (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .valid_i(pool_valid),
        .data_i (pool_data),
        .done_o (feat_done),
        .wen_o  (feat_wen),
        .full_i (fifo_full),
        .data_o (feat_data)
    );

    double_fifo #(
        .WORD_SIZE (WORD_SIZE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .wen_i  (feat_wen),
        .data_i (feat_data),
        .full_o (fifo_full),
        .ren_i  (fc_ren),
        .empty_o(fifo_empty),
        .data_o (fifo_data)
    );

    fc_layer #(
        .WORD_SIZE(WORD_SIZE),
        .INT_BITS (INT_BITS)
    ) u_fc (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .data_i (fifo_data),
        .empty_i(fifo_empty),
        .ren_o  (fc_ren),
        .valid_o(valid_o),
        .yumi_i (yumi_i),
        .data_o (data_o)
    );

endmodule

`default_nettype wire

// ==== verification/zynet_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module zynet_tb;
    import zynet_coef_pkg::*;

    localparam int WORD_SIZE    = 16;
    localparam int CLK_PERIOD   = 10;
    // generous bound per frame, covers input gaps and slow yumi
    localparam int FRAME_CYCLES = 300;
    localparam int NUM_FRAMES   = 18;
    localparam int TIMEOUT_NS   = (NUM_FRAMES * FRAME_CYCLES + 200) * CLK_PERIOD;
    localparam longint MAX_WORD = (longint'(1) <<< (WORD_SIZE - 1)) - 1;
    localparam longint MIN_WORD = -MAX_WORD - 1;

    logic clk;
    logic reset;
    logic start;
    logic signed [WORD_SIZE-1:0] sample;
    logic sample_valid;
    logic ready;
    logic [OUTPUT_SIZE-1:0][WORD_SIZE-1:0] scores;
    logic scores_valid;
    logic yumi;

    logic [31:0] lfsr = 32'hd5e5_d5fd;
    logic signed [WORD_SIZE-1:0] frame [INPUT_LENGTH];
    logic [OUTPUT_SIZE-1:0][WORD_SIZE-1:0] exp_q [$];
    bit yumi_delays = 1'b0;
    int error_count = 0;
    int vector_count = 0;
    int test_count = 0;
    int mark_errors = 0;
    int mark_vectors = 0;

    zynet dut (
        .clk_i  (clk),
        .reset_i(reset),
        .start_i(start),
        .data_i (sample),
        .valid_i(sample_valid),
        .ready_o(ready),
        .data_o (scores),
        .valid_o(scores_valid),
        .yumi_i (yumi)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic longint clip_word(input longint v);
        if (v > MAX_WORD) return MAX_WORD;
        if (v < MIN_WORD) return MIN_WORD;
        return v;
    endfunction

    task automatic fill_frame(input bit full_scale);
        logic [31:0] bits;
        for (int i = 0; i < INPUT_LENGTH; i++) begin
            if (full_scale) begin
                frame[i] = (take_bits(1) != 0) ? WORD_SIZE'(MAX_WORD) : WORD_SIZE'(MIN_WORD);
            end else begin
                // twelve bit samples keep most sums inside the range
                bits = take_bits(12);
                frame[i] = {{(WORD_SIZE - 12){bits[11]}}, bits[11:0]};
            end
        end
    endtask

    // conv, abs average, then fc with bias, all on the saturating rule
    task automatic predict_scores();
        longint acc;
        longint conv;
        longint pool_sum;
        longint feature [NUM_KERNELS];
        logic [OUTPUT_SIZE-1:0][WORD_SIZE-1:0] vec;
        for (int k = 0; k < NUM_KERNELS; k++) begin
            pool_sum = 0;
            for (int j = 0; j < CONV_LENGTH; j++) begin
                acc = 0;
                for (int t = 0; t < KERNEL_LENGTH; t++) begin
                    acc += longint'(frame[j + t]) * longint'(KERNEL_COEF[k][t]);
                end
                conv = clip_word(acc >>> COEF_FRAC_BITS);
                if (conv == MIN_WORD) conv = MAX_WORD;
                else if (conv < 0) conv = -conv;
                pool_sum += conv;
            end
            feature[k] = pool_sum >> POOL_SHIFT;
        end
        for (int o = 0; o < OUTPUT_SIZE; o++) begin
            acc = 0;
            for (int k = 0; k < NUM_KERNELS; k++) begin
                acc += feature[k] * longint'(FC_WEIGHT[o][k]);
            end
            vec[o] = WORD_SIZE'(clip_word((acc >>> COEF_FRAC_BITS) + longint'(FC_BIAS[o])));
        end
        exp_q.push_back(vec);
    endtask

    // caller sits on a rising edge
    task automatic drive_frame(input int count, input bit gaps);
        int idx;
        bit hold_off;
        idx = 0;
        start <= 1'b1;
        sample_valid <= 1'b0;
        @(posedge clk);
        start <= 1'b0;
        while (idx < count) begin
            hold_off = gaps && (take_bits(2) == 0);
            sample_valid <= !hold_off;
            sample <= frame[idx];
            @(negedge clk);
            if (sample_valid && ready) idx++;
            @(posedge clk);
        end
        sample_valid <= 1'b0;
    endtask

    task automatic run_frames(input int n, input bit full_scale, input bit gaps);
        for (int f = 0; f < n; f++) begin
            fill_frame(full_scale);
            predict_scores();
            drive_frame(INPUT_LENGTH, gaps);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        start <= 1'b0;
        sample_valid <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s: %0d vectors, %0d errors", test_count, name,
                 vector_count - mark_vectors, error_count - mark_errors);
        mark_errors = error_count;
        mark_vectors = vector_count;
    endtask

    task automatic check_vector(input logic [OUTPUT_SIZE-1:0][WORD_SIZE-1:0] actual);
        logic [OUTPUT_SIZE-1:0][WORD_SIZE-1:0] expected;
        if (exp_q.size() == 0) begin
            $display("score vector at %0t ns arrived with no frame pending", $time);
            error_count++;
        end else begin
            expected = exp_q.pop_front();
            vector_count++;
            for (int o = 0; o < OUTPUT_SIZE; o++) begin
                if (actual[o] !== expected[o]) begin
                    $display("FAILED at %0t ns: dut.data_o[%0d] expected %0d got %0d", $time, o,
                             $signed(expected[o]), $signed(actual[o]));
                    error_count++;
                end
            end
        end
    endtask

    // output side, sampled on the falling edge
    initial begin : consume_scores
        logic [OUTPUT_SIZE-1:0][WORD_SIZE-1:0] held_data;
        bit held;
        bit take;
        held = 1'b0;
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            take = 1'b0;
            if (!scores_valid) begin
                held = 1'b0;
            end else begin
                for (int o = 0; o < OUTPUT_SIZE; o++) begin
                    if (held && scores[o] !== held_data[o]) begin
                        $display("FAILED at %0t ns: dut.data_o[%0d] not held, was %0d got %0d",
                                 $time, o, $signed(held_data[o]), $signed(scores[o]));
                        error_count++;
                    end
                end
                held = 1'b1;
                held_data = scores;
                if (yumi) begin
                    held = 1'b0;
                    check_vector(scores);
                end else begin
                    take = !yumi_delays || (take_bits(2) == 2'd3);
                end
            end
            @(posedge clk);
            yumi <= take;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the DUT stopped delivering scores", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset = 1'b1;
        start = 1'b0;
        sample = '0;
        sample_valid = 1'b0;
        yumi = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        run_frames(1, 1'b0, 1'b0);
        wait_drain();
        report_test("single random frame");

        run_frames(4, 1'b0, 1'b0);
        wait_drain();
        report_test("back to back frames");

        run_frames(4, 1'b0, 1'b1);
        wait_drain();
        report_test("input valid gaps");

        yumi_delays = 1'b1;
        run_frames(4, 1'b0, 1'b0);
        wait_drain();
        yumi_delays = 1'b0;
        report_test("delayed yumi");

        run_frames(3, 1'b1, 1'b0);
        wait_drain();
        report_test("full scale saturation");

        // reset hits while this frame is still inside the engine
        fill_frame(1'b0);
        drive_frame(INPUT_LENGTH, 1'b0);
        apply_reset();
        repeat (40) @(posedge clk);
        @(negedge clk);
        if (ready !== 1'b1) begin
            $display("FAILED at %0t ns: dut.ready_o expected 1 got %b", $time, ready);
            error_count++;
        end
        if (scores_valid !== 1'b0) begin
            $display("FAILED at %0t ns: dut.valid_o expected 0 got %b", $time, scores_valid);
            error_count++;
        end
        @(posedge clk);
        run_frames(1, 1'b0, 1'b0);
        wait_drain();
        report_test("reset mid frame");

        $display("%0d tests, %0d vectors checked, %0d errors", test_count, vector_count,
                 error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/zynet_ctrl_pkg.sv
source/zynet_coef_pkg.sv
source/conv_layer.sv
source/pooling_layer.sv
source/fc_output_layer.sv
source/double_fifo.sv
source/fc_layer.sv
source/zynet.sv
verification/zynet_tb.sv
